/* design/colmix_params.svh */
// Colour mixer sizes and video timing
`ifndef COLMIX_PARAMS_SVH
`define COLMIX_PARAMS_SVH

// palette RAM address width, two bytes per palette entry
`define PAL_AW      8
// width of the pixel index from the graphics layers
`define PXL_W       7
// bits per colour channel
`define COL_W       5

// pixels per line and visible pixels per line
`define H_TOTAL     40
`define H_ACTIVE    32
// lines per frame and visible lines per frame
`define V_TOTAL     12
`define V_ACTIVE    8

// pixel periods between the index sample and the colour output
`define BLANK_DLY   2

`endif

/* design/colmix_pkg.sv */
// Colour mixer shared types
`include "colmix_params.svh"

package colmix_pkg;

    typedef struct packed {
        logic               psel;     // slave selected
        logic               penable;  // high in the access phase
        logic               pwrite;   // write when high, read when low
        logic [`PAL_AW-1:0] paddr;    // byte address into the palette
        logic [7:0]         pwdata;   // write byte
    } apb_req_t;

    typedef struct packed {
        logic [7:0] prdata;  // read byte, valid together with pready
        logic       pready;  // transfer completes in this cycle
    } apb_rsp_t;

    typedef struct packed {
        logic               we;     // single cycle write strobe
        logic [`PAL_AW-1:0] addr;   // byte address, also the read address
        logic [7:0]         wdata;  // byte to store
    } pal_port_t;

    // packs into 15 bits with red in the low bits
    typedef struct packed {
        logic [`COL_W-1:0] blue;
        logic [`COL_W-1:0] green;
        logic [`COL_W-1:0] red;
    } rgb_t;

    typedef struct packed {
        logic pxl_cen;  // pixel enable, one cycle in two
        logic lhbl;     // high while the line is visible
        logic lvbl;     // high while the frame is visible
    } vid_sync_t;

    typedef enum logic [1:0] {
        ST_IDLE,    // waiting for a setup phase
        ST_SETUP,   // setup seen, this is the first access cycle
        ST_RDWAIT   // second access cycle of a read
    } bridge_state_e;

endpackage

/* design/video_timing.sv */
// Video timing generator
`timescale 1ns/1ps
`include "colmix_params.svh"

module video_timing import colmix_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    output vid_sync_t sync
);

    localparam int HW = $clog2(`H_TOTAL);
    localparam int VW = $clog2(`V_TOTAL);

    logic          pxl_cen;   // toggles every clock
    logic          lhbl;
    logic          lvbl;
    logic [HW-1:0] hcnt;      // pixel position within the line
    logic [VW-1:0] vcnt;      // line position within the frame
    logic [HW-1:0] hcnt_nxt;
    logic [VW-1:0] vcnt_nxt;
    logic          hwrap;     // last pixel of the line

    assign hwrap = (hcnt == HW'(`H_TOTAL - 1));

    // the vertical count only steps at the end of a line
    always_comb begin
        hcnt_nxt = hwrap ? '0 : hcnt + 1'b1;
        vcnt_nxt = vcnt;
        if (hwrap) begin
            vcnt_nxt = (vcnt == VW'(`V_TOTAL - 1)) ? '0 : vcnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pxl_cen <= 1'b0;   // first enable lands on the cycle after reset
            hcnt    <= '0;
            vcnt    <= '0;
            lhbl    <= 1'b1;   // position zero is the first visible pixel
            lvbl    <= 1'b1;
        end else begin
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                hcnt <= hcnt_nxt;
                vcnt <= vcnt_nxt;
                // blanking follows the counters on the same edge
                lhbl <= (hcnt_nxt < HW'(`H_ACTIVE));
                lvbl <= (vcnt_nxt < VW'(`V_ACTIVE));
            end
        end
    end

    assign sync = '{pxl_cen: pxl_cen, lhbl: lhbl, lvbl: lvbl};

endmodule

/* design/apb_pal_bridge.sv */
// APB slave for the palette RAM
`timescale 1ns/1ps

module apb_pal_bridge import colmix_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  apb_req_t   req,
    output apb_rsp_t   rsp,
    output pal_port_t  pal,
    input  logic [7:0] pal_q
);

    bridge_state_e state;
    bridge_state_e state_nxt;
    logic          pready;      // registered so it never depends on the bus inputs
    logic          pready_nxt;
    logic          setup;       // setup phase on the bus
    logic          access;      // access phase on the bus

    assign setup  = req.psel & ~req.penable;
    assign access = req.psel & req.penable;

    // writes finish in the first access cycle, reads in the second one
    always_comb begin
        state_nxt  = state;
        pready_nxt = 1'b0;
        case (state)
            ST_IDLE: begin
                if (setup) begin
                    state_nxt  = ST_SETUP;
                    pready_nxt = req.pwrite;  // zero wait states for writes
                end
            end
            ST_SETUP: begin
                if (access && !req.pwrite) begin
                    state_nxt  = ST_RDWAIT;    // RAM output is ready next cycle
                    pready_nxt = 1'b1;
                end else begin
                    state_nxt = ST_IDLE;
                end
            end
            ST_RDWAIT: state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            pready <= 1'b0;
        end else begin
            state  <= state_nxt;
            pready <= pready_nxt;
        end
    end

    // the address goes to the RAM from the setup phase onwards
    assign pal = '{we:    (state == ST_SETUP) & access & req.pwrite,
                   addr:  req.paddr,
                   wdata: req.pwdata};

    // the RAM keeps reading the held address, so pal_q is stable in the wait
    assign rsp = '{prdata: pal_q, pready: pready};

endmodule

/* design/pal_ram.sv */
// Dual-port palette RAM
`timescale 1ns/1ps
`include "colmix_params.svh"

module pal_ram import colmix_pkg::*; (
    input  logic               clk,
    input  pal_port_t          cpu,
    output logic [7:0]         cpu_q,
    input  logic [`PAL_AW-1:0] vid_addr,
    output logic [7:0]         vid_q
);

    localparam int DEPTH = 1 << `PAL_AW;

    logic [7:0] mem [DEPTH];   // two bytes per palette entry

    // CPU port, read and write on the same address
    always_ff @(posedge clk) begin
        if (cpu.we) begin
            mem[cpu.addr] <= cpu.wdata;
        end
        cpu_q <= mem[cpu.addr];   // returns the byte from before the write
    end

    // video port is read only
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr];   // a same cycle CPU write is not seen yet
    end

endmodule

/* design/blank_dly.sv */
// Blanking delay and colour masking
`timescale 1ns/1ps
`include "colmix_params.svh"

module blank_dly import colmix_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  vid_sync_t sync,
    input  rgb_t      col_in,
    output rgb_t      col_out,
    output logic      lhbl_dly,
    output logic      lvbl_dly
);

    localparam int DLY = `BLANK_DLY;   // at least two stages

    logic [DLY-1:0] hbl_sh;   // horizontal blank history, newest in bit 0
    logic [DLY-1:0] vbl_sh;   // vertical blank history
    logic           vis;      // delayed sample is inside the picture

    assign vis = hbl_sh[DLY-1] & vbl_sh[DLY-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            hbl_sh   <= '0;
            vbl_sh   <= '0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            col_out  <= '0;   // black until the first visible pixel
        end else if (sync.pxl_cen) begin
            hbl_sh   <= {hbl_sh[DLY-2:0], sync.lhbl};
            vbl_sh   <= {vbl_sh[DLY-2:0], sync.lvbl};
            lhbl_dly <= hbl_sh[DLY-1];
            lvbl_dly <= vbl_sh[DLY-1];
            // colour and blanking load on the same edge, so they never split
            col_out  <= vis ? col_in : '0;
        end
    end

endmodule

/* design/colmix.sv */
// Palette fetch and colour assembly
`timescale 1ns/1ps
`include "colmix_params.svh"

module colmix import colmix_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  vid_sync_t          sync,
    input  logic [`PXL_W-1:0]  gfx_pxl,
    output logic [`PAL_AW-1:0] vid_addr,
    input  logic [7:0]         vid_q,
    output rgb_t               col
);

    logic              half;     // high on the low byte fetch cycle
    logic [`PXL_W-1:0] pxl_q;    // index kept for the second fetch
    logic [7:0]        hi_byte;  // high byte, it arrives first

    // high byte is addressed straight from the input on the enable cycle
    assign vid_addr = half ? {pxl_q, 1'b0} : {gfx_pxl, 1'b1};

    // the fetch phase restarts on every pixel enable
    always_ff @(posedge clk) begin
        if (rst) begin
            half <= 1'b1;   // toggles low for the high byte fetch of the first enable
        end else if (sync.pxl_cen) begin
            half <= 1'b1;
        end else begin
            half <= ~half;
        end
    end

    always_ff @(posedge clk) begin
        if (sync.pxl_cen) begin
            pxl_q <= gfx_pxl;
        end
        if (half) begin
            hi_byte <= vid_q;   // RAM answer to the previous high byte address
        end
    end

    // low byte is on vid_q during the next enable, so the pair is complete
    always_ff @(posedge clk) begin
        if (sync.pxl_cen) begin
            col <= rgb_t'({hi_byte[6:0], vid_q});   // bit 7 of the high byte is spare
        end
    end

endmodule

/* design/video_top.sv */
// Colour mixing stage top level
`timescale 1ns/1ps
`include "colmix_params.svh"

module video_top import colmix_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  apb_req_t          apb_req,
    output apb_rsp_t          apb_rsp,
    input  logic [`PXL_W-1:0] gfx_pxl,
    output vid_sync_t         sync,
    output rgb_t              rgb,
    output logic              lhbl_dly,
    output logic              lvbl_dly
);

    pal_port_t          pal;       // CPU side RAM request
    logic [7:0]         pal_q;     // CPU side read byte
    logic [`PAL_AW-1:0] vid_addr;  // video side fetch address
    logic [7:0]         vid_q;     // video side read byte
    rgb_t               col;       // assembled colour before the blank delay

    video_timing u_timing (
        .clk   (clk),
        .rst   (rst),
        .sync  (sync)
    );

    apb_pal_bridge u_bridge (
        .clk   (clk),
        .rst   (rst),
        .req   (apb_req),
        .rsp   (apb_rsp),
        .pal   (pal),
        .pal_q (pal_q)
    );

    pal_ram u_ram (
        .clk      (clk),
        .cpu      (pal),
        .cpu_q    (pal_q),
        .vid_addr (vid_addr),
        .vid_q    (vid_q)
    );

    colmix u_colmix (
        .clk      (clk),
        .rst      (rst),
        .sync     (sync),
        .gfx_pxl  (gfx_pxl),
        .vid_addr (vid_addr),
        .vid_q    (vid_q),
        .col      (col)
    );

    blank_dly u_blank (
        .clk      (clk),
        .rst      (rst),
        .sync     (sync),
        .col_in   (col),
        .col_out  (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

endmodule

/* verif/video_asserts.sv */
// Bound assertions for the video top
`timescale 1ns/1ps

module video_asserts import colmix_pkg::*; (
    input logic      clk,
    input logic      rst,
    input apb_req_t  apb_req,
    input apb_rsp_t  apb_rsp,
    input vid_sync_t sync,
    input rgb_t      rgb,
    input logic      lhbl_dly,
    input logic      lvbl_dly
);

    // the slave only completes a transfer inside an access phase
    pready_in_access: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
        else $error("pready seen outside an APB access phase");

    // blanked output has to be black
    black_when_blanked: assert property (@(posedge clk) disable iff (rst)
        (!lhbl_dly || !lvbl_dly) |-> (rgb == '0))
        else $error("rgb is not black while the delayed blanking is active");

    // pixel enable never lasts two cycles
    cen_single_cycle: assert property (@(posedge clk) disable iff (rst)
        sync.pxl_cen |=> !sync.pxl_cen)
        else $error("pxl_cen high on two consecutive cycles");

endmodule

bind video_top video_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .sync     (sync),
    .rgb      (rgb),
    .lhbl_dly (lhbl_dly),
    .lvbl_dly (lvbl_dly)
);

/* verif/tb_clkgen.sv */
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD  = 40,  // clock period in ns
    parameter int RST_CYC = 5    // cycles with reset held high
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;  // free running for the whole run
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYC) @(posedge clk);
        rst <= 1'b0;  // released on an edge like any other input
    end

endmodule

/* verif/tb_video_top.sv */
// Colour mixing stage testbench
`timescale 1ns/1ps
`include "colmix_params.svh"

module tb_video_top import colmix_pkg::*;;

    localparam int N_RW       = 16;                              // write and read pairs
    localparam int N_UPD      = 8;                               // bytes rewritten in vblank
    localparam int FRAME_CYC  = 2 * `H_TOTAL * `V_TOTAL;         // two clocks per pixel
    localparam int PIX_TESTS  = 2;
    localparam int APB_XFERS  = 2 * N_RW + 256 + N_UPD;
    localparam longint TIMEOUT_NS = 40 * (3 * FRAME_CYC * PIX_TESTS + 20 * APB_XFERS);
    localparam int HIST       = 8192;                            // pixel history depth

    logic              clk;
    logic              rst;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;
    logic [`PXL_W-1:0] gfx_pxl;
    vid_sync_t         sync;
    rgb_t              rgb;
    logic              lhbl_dly;
    logic              lvbl_dly;

    logic [7:0]        mirror [256];     // what the palette RAM should hold
    rgb_t              col_hist [HIST];  // model colour per pixel enable
    bit                chk_hist [HIST];  // colour of that pixel is compared
    bit                chk_en;
    bit                pix_run;
    logic [`PXL_W-1:0] pix_mask;         // narrows the index range in the update test
    int                errors;
    int                checks;
    int                chk_count;        // visible colours actually compared
    int                edge_n;           // edges since reset was released
    int                m_prev;
    int                cnt;
    int                k_src;
    bit                exp_h;
    bit                exp_v;
    logic [7:0]        addrs [N_RW];
    logic [7:0]        rd_byte;

    tb_clkgen #(.PERIOD(40), .RST_CYC(5)) u_clkgen (.clk(clk), .rst(rst));

    video_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .gfx_pxl  (gfx_pxl),
        .sync     (sync),
        .rgb      (rgb),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly)
    );

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // visibility of the pixel at a given count of pixel enables since reset
    function automatic bit h_visible(input int p);
        return (p % `H_TOTAL) < `H_ACTIVE;
    endfunction

    function automatic bit v_visible(input int p);
        return ((p / `H_TOTAL) % `V_TOTAL) < `V_ACTIVE;
    endfunction

    // high byte at 2p+1 carries the upper 7 bits, low byte at 2p the lower 8
    function automatic rgb_t entry_colour(input logic [`PXL_W-1:0] p);
        logic [7:0] hi;
        logic [7:0] lo;
        hi = mirror[{p, 1'b1}];
        lo = mirror[{p, 1'b0}];
        return rgb_t'({hi[6:0], lo});
    endfunction

    task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
        int waits;
        waits = 0;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        while (!apb_rsp.pready) begin  // the watchdog catches a slave that never answers
            waits++;
            @(posedge clk);
        end
        apb_req <= '0;
        mirror[addr] = data;
        check_val("write wait states", 32'(waits), 32'd0);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [7:0] data);
        int waits;
        waits = 0;
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 8'h00};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        while (!apb_rsp.pready) begin
            waits++;
            @(posedge clk);
        end
        data = apb_rsp.prdata;   // valid in the cycle that completes the read
        apb_req <= '0;
        check_val("read wait states", 32'(waits), 32'd1);
    endtask

    // new random index every clock, the DUT takes it on the enable edge
    always @(posedge clk) begin
        if (pix_run) begin
            gfx_pxl <= `PXL_W'($urandom) & pix_mask;
        end
    end

    // model of the timing and the pipeline, checked on every edge after reset
    always @(posedge clk) begin
        if (rst) begin
            edge_n = 0;
        end else begin
            m_prev = edge_n - 1;                      // outputs show the state after this edge
            cnt    = (m_prev + 1) / 2;                // pixel enables seen so far
            check_val("pxl_cen", 32'(sync.pxl_cen), 32'(m_prev >= 0 && m_prev % 2 == 0));
            check_val("lhbl", 32'(sync.lhbl), 32'(h_visible(cnt)));
            check_val("lvbl", 32'(sync.lvbl), 32'(v_visible(cnt)));
            k_src = cnt - 3;                          // pixel two enables behind the last one
            exp_h = (k_src >= 0) ? h_visible(k_src) : 1'b0;
            exp_v = (k_src >= 0) ? v_visible(k_src) : 1'b0;
            check_val("lhbl_dly", 32'(lhbl_dly), 32'(exp_h));
            check_val("lvbl_dly", 32'(lvbl_dly), 32'(exp_v));
            if (!(exp_h && exp_v)) begin
                check_val("rgb", 32'(rgb), 32'd0);    // black in every blanked cycle
            end else if (k_src < HIST && chk_hist[k_src]) begin
                check_val("rgb", 32'(rgb), 32'(col_hist[k_src]));
                chk_count++;
            end
            if (edge_n % 2 == 1 && (edge_n - 1) / 2 < HIST) begin  // enable edge, sample the index
                col_hist[(edge_n - 1) / 2] = entry_colour(gfx_pxl);
                chk_hist[(edge_n - 1) / 2] = chk_en;
            end
            edge_n++;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the DUT stopped making progress");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hfc15_3ac4));
        apb_req  = '0;
        gfx_pxl  = '0;
        chk_en   = 1'b0;
        pix_run  = 1'b0;
        pix_mask = '1;
        errors   = 0;
        checks   = 0;
        chk_count = 0;
        edge_n   = 0;
        @(negedge rst);
        @(posedge clk);
        // outputs right after reset
        check_val("pready", 32'(apb_rsp.pready), 32'd0);
        check_val("rgb", 32'(rgb), 32'd0);
        check_val("lhbl_dly", 32'(lhbl_dly), 32'd0);
        check_val("lvbl_dly", 32'(lvbl_dly), 32'd0);
        // random writes, then reads of the same addresses
        for (int i = 0; i < N_RW; i++) begin
            addrs[i] = 8'($urandom);
            apb_write(addrs[i], 8'($urandom));
        end
        for (int i = 0; i < N_RW; i++) begin
            apb_read(addrs[i], rd_byte);
            check_val("prdata", 32'(rd_byte), 32'(mirror[addrs[i]]));
        end
        // full palette, then two frames of random pixels
        for (int a = 0; a < 256; a++) begin
            apb_write(8'(a), 8'($urandom));
        end
        @(posedge clk);
        pix_run <= 1'b1;
        chk_en  <= 1'b1;
        repeat (2 * FRAME_CYC) @(posedge clk);
        // rewrite a few entries in the vertical blank
        while (sync.lvbl) @(posedge clk);
        pix_mask <= `PXL_W'(7);
        for (int a = 0; a < N_UPD; a++) begin
            apb_write(8'(a), 8'($urandom));   // entries 0 to 3, entries 4 to 7 stay
        end
        while (!sync.lvbl) @(posedge clk);
        repeat (FRAME_CYC) @(posedge clk);
        chk_en <= 1'b0;
        @(posedge clk);
        assert (chk_count > 0) else begin
            errors++;
            $display("no visible pixel colour was compared");
        end
        $display("errors: %0d, checks: %0d, colours compared: %0d", errors, checks, chk_count);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+design
design/colmix_pkg.sv
design/video_timing.sv
design/apb_pal_bridge.sv
design/pal_ram.sv
design/blank_dly.sv
design/colmix.sv
design/video_top.sv
verif/video_asserts.sv
verif/tb_clkgen.sv
verif/tb_video_top.sv

/* run.sh */
#!/bin/sh
# build and run the colour mixer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_video_top \
    -f sim.f -o sim_video || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_video 2>&1)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1
